// ==== csr_array.sv ====
/*
 * machine mode csrs mie, mtvec, mscratch, mepc and mcause
 * with read-modify-write, trap entry and mret
 */
`timescale 1ns/1ps

module csr_array (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_exec_pkg::ex_cmd_t  cmd,
	input  logic [31:0]           rs1,
	input  logic                  cpu_stat,
	input  logic [29:0]           pc_excep,
	output logic [31:0]           csr_rd_data,
	output logic                  trap_take,
	output logic                  mret_take,
	output logic [29:0]           mtvec,
	output logic [29:0]           mepc,
	output rv_exec_pkg::csr_mie_t csr_mie
);

	import rv_exec_pkg::*;

	logic [31:0] mscratch;
	logic [31:0] mcause;
	logic [31:0] mie_word;
	logic [31:0] csr_src;
	logic [31:0] csr_wdata;
	logic        is_csr;
	logic        is_ecall;
	logic        is_illegal;
	logic        csr_we;

	assign is_csr     = (cmd.kind == k_csr);
	assign is_ecall   = (cmd.kind == k_ecall);
	assign is_illegal = (cmd.kind == k_illegal);

	assign trap_take = (is_ecall | is_illegal) & cpu_stat;
	assign mret_take = (cmd.kind == k_mret) & cpu_stat;

	// mie bits sit at 11, 7 and 3
	assign mie_word = {20'd0, csr_mie.meie, 3'd0, csr_mie.mtie, 3'd0, csr_mie.msie, 3'd0};

	always_comb begin
		case (cmd.imm12)
			csr_mie_adr:      csr_rd_data = mie_word;
			csr_mtvec_adr:    csr_rd_data = {mtvec, 2'b00};
			csr_mscratch_adr: csr_rd_data = mscratch;
			csr_mepc_adr:     csr_rd_data = {mepc, 2'b00};
			csr_mcause_adr:   csr_rd_data = mcause;
			default:          csr_rd_data = 32'd0;
		endcase
	end

	// funct3 bit 2 picks the immediate form
	assign csr_src = cmd.funct3[2] ? {27'd0, cmd.uimm} : rs1;

	always_comb begin
		case (cmd.funct3[1:0])
			2'b01:   csr_wdata = csr_src;
			2'b10:   csr_wdata = csr_rd_data | csr_src;
			2'b11:   csr_wdata = csr_rd_data & ~csr_src;
			default: csr_wdata = csr_rd_data;
		endcase
	end

	// set/clear with a zero source rewrite the old value
	assign csr_we = is_csr & cpu_stat & (cmd.funct3[1:0] != 2'b00);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_mie  <= '0;
			mtvec    <= mtvec_reset;
			mscratch <= 32'd0;
			mepc     <= 30'd0;
			mcause   <= 32'd0;
		end else if (trap_take) begin
			mepc   <= pc_excep;
			mcause <= is_ecall ? cause_ecall_m : cause_illegal;
		end else if (csr_we) begin
			case (cmd.imm12)
				csr_mie_adr: begin
					csr_mie.meie <= csr_wdata[11];
					csr_mie.mtie <= csr_wdata[7];
					csr_mie.msie <= csr_wdata[3];
				end
				csr_mtvec_adr: begin
					mtvec <= csr_wdata[31:2];
				end
				csr_mscratch_adr: begin
					mscratch <= csr_wdata;
				end
				csr_mepc_adr: begin
					mepc <= csr_wdata[31:2];
				end
				csr_mcause_adr: begin
					mcause <= csr_wdata;
				end
				default: begin
					// unknown address, nothing to update
				end
			endcase
		end
	end

endmodule

// ==== exec_alu.sv ====
/*
 * integer alu: add/sub, shifts, compares and logic ops,
 * result selection and compare flags for branching
 */
`timescale 1ns/1ps

module exec_alu (
	input  logic [31:0]            alu_a,
	input  logic [31:0]            alu_b,
	input  rv_exec_pkg::ex_kind_e  kind,
	input  logic [2:0]             funct3,
	input  logic                   alt,
	output logic [31:0]            alu_result,
	output rv_exec_pkg::alu_flags_t flags
);

	import rv_exec_pkg::*;

	logic        sub;
	logic [31:0] b_op;
	logic [31:0] alu_add;
	logic [31:0] alu_sll;
	logic [31:0] alu_srl;
	logic [31:0] alu_sra;
	logic [31:0] alu_shr;
	logic        lt_s;
	logic        lt_u;
	logic        is_ldst;

	// subtract only for register-register ops with alt set
	assign sub     = (kind == k_alu) & alt;
	assign b_op    = sub ? ~alu_b : alu_b;
	assign alu_add = alu_a + b_op + {31'd0, sub};

	assign alu_sll = alu_a << alu_b[4:0];
	assign alu_srl = alu_a >> alu_b[4:0];
	assign alu_sra = $signed(alu_a) >>> alu_b[4:0];
	assign alu_shr = alt ? alu_sra : alu_srl;

	assign lt_s = $signed(alu_a) < $signed(alu_b);
	assign lt_u = alu_a < alu_b;

	// branches compare the raw operands
	assign flags.seq  = (alu_a == alu_b);
	assign flags.slt  = lt_s;
	assign flags.sltu = lt_u;

	// loads and stores always need the address sum
	assign is_ldst = (kind == k_ld) | (kind == k_st);

	always_comb begin
		if (is_ldst) begin
			alu_result = alu_add;
		end else begin
			case (funct3)
				3'b000:  alu_result = alu_add;
				3'b001:  alu_result = alu_sll;
				3'b010:  alu_result = {31'd0, lt_s};
				3'b011:  alu_result = {31'd0, lt_u};
				3'b100:  alu_result = alu_a ^ alu_b;
				3'b101:  alu_result = alu_shr;
				3'b110:  alu_result = alu_a | alu_b;
				default: alu_result = alu_a & alu_b;
			endcase
		end
	end

endmodule

// ==== exec_branch.sv ====
/*
 * jump target adder, pc+4, branch condition and redirect merge
 */
`timescale 1ns/1ps

module exec_branch (
	input  logic [31:0]             adr_a,
	input  logic [31:0]             adr_b,
	input  logic [29:0]             pc,
	input  rv_exec_pkg::ex_kind_e   kind,
	input  logic [2:0]              funct3,
	input  rv_exec_pkg::alu_flags_t flags,
	input  logic                    trap_take,
	input  logic                    mret_take,
	input  logic [29:0]             mtvec,
	input  logic [29:0]             mepc,
	output logic [31:0]             jump_adr,
	output logic [31:0]             pcp4,
	output logic [29:0]             jmp_adr,
	output logic                    jmp_condition
);

	import rv_exec_pkg::*;

	logic br_hit;

	assign jump_adr = adr_a + adr_b;
	assign pcp4     = {pc, 2'b00} + 32'd4;

	always_comb begin
		case (funct3)
			3'b000:  br_hit = flags.seq;
			3'b001:  br_hit = ~flags.seq;
			3'b100:  br_hit = flags.slt;
			3'b101:  br_hit = ~flags.slt;
			3'b110:  br_hit = flags.sltu;
			3'b111:  br_hit = ~flags.sltu;
			default: br_hit = 1'b0;
		endcase
	end

	assign jmp_condition = (kind == k_jal) | (kind == k_jalr) |
		((kind == k_br) & br_hit) | trap_take | mret_take;

	// trap wins over mret, then the adder target
	assign jmp_adr = trap_take ? mtvec :
		mret_take ? mepc : jump_adr[31:2];

endmodule

// ==== exec_operand_sel.sv ====
/*
 * operand selection: immediate extension, alu operands
 * and address adder operands
 */
`timescale 1ns/1ps

module exec_operand_sel (
	input  rv_exec_pkg::ex_cmd_t cmd,
	output logic [31:0]          alu_a,
	output logic [31:0]          alu_b,
	output logic [31:0]          adr_a,
	output logic [31:0]          adr_b
);

	import rv_exec_pkg::*;

	logic [31:0] imm12_sext;
	logic [31:0] shamt_zext;
	logic [31:0] upper_imm;
	logic [31:0] jal_ofs;
	logic [31:0] br_ofs;
	logic [31:0] pc_byte;

	assign imm12_sext = {{20{cmd.imm12[11]}}, cmd.imm12};
	assign shamt_zext = {27'd0, cmd.uimm};
	assign upper_imm  = {cmd.imm20, 12'd0};

	// jal offset holds bits 20:1, branch offset bits 12:1
	assign jal_ofs = {{11{cmd.imm20[19]}}, cmd.imm20, 1'b0};
	assign br_ofs  = {{19{cmd.imm12[11]}}, cmd.imm12, 1'b0};

	assign pc_byte = {cmd.pc, 2'b00};

	assign alu_a = cmd.rs1_data;

	always_comb begin
		case (cmd.kind)
			k_ld, k_alui, k_st: alu_b = imm12_sext;
			k_alui_shamt:       alu_b = shamt_zext;
			default:            alu_b = cmd.rs2_data;
		endcase
	end

	// jalr is relative to rs1, everything else to the pc
	assign adr_a = (cmd.kind == k_jalr) ? cmd.rs1_data : pc_byte;

	always_comb begin
		case (cmd.kind)
			k_auipc: adr_b = upper_imm;
			k_jal:   adr_b = jal_ofs;
			k_jalr:  adr_b = imm12_sext;
			default: adr_b = br_ofs;
		endcase
	end

endmodule

// ==== execution.sv ====
/*
 * rv32i execute stage top: operands, alu, branch, csrs
 * and the registered bundle to memory access
 */
`timescale 1ns/1ps

module execution (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_exec_pkg::ex_cmd_t  cmd,
	input  logic                  cpu_stat,
	input  logic [29:0]           pc_excep,
	output rv_exec_pkg::ex_ma_t   ma,
	output logic [29:0]           jmp_adr,
	output logic                  jmp_condition,
	output logic                  exception,
	output rv_exec_pkg::csr_mie_t csr_mie
);

	import rv_exec_pkg::*;

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] adr_a;
	logic [31:0] adr_b;
	logic [31:0] alu_result;
	alu_flags_t  flags;
	logic [31:0] jump_adr;
	logic [31:0] pcp4;
	logic [31:0] csr_rd_data;
	logic        trap_take;
	logic        mret_take;
	logic [29:0] mtvec;
	logic [29:0] mepc;
	logic [31:0] rd_data;

	// ma register
	logic        ld_q;
	logic        st_q;
	logic        wbk_q;
	logic [4:0]  rd_adr_q;
	logic [31:0] rd_data_q;
	logic [31:0] st_data_q;
	logic [2:0]  ldst_code_q;

	exec_operand_sel u_operand_sel (
		.cmd   (cmd),
		.alu_a (alu_a),
		.alu_b (alu_b),
		.adr_a (adr_a),
		.adr_b (adr_b)
	);

	exec_alu u_alu (
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.kind       (cmd.kind),
		.funct3     (cmd.funct3),
		.alt        (cmd.alt),
		.alu_result (alu_result),
		.flags      (flags)
	);

	exec_branch u_branch (
		.adr_a         (adr_a),
		.adr_b         (adr_b),
		.pc            (cmd.pc),
		.kind          (cmd.kind),
		.funct3        (cmd.funct3),
		.flags         (flags),
		.trap_take     (trap_take),
		.mret_take     (mret_take),
		.mtvec         (mtvec),
		.mepc          (mepc),
		.jump_adr      (jump_adr),
		.pcp4          (pcp4),
		.jmp_adr       (jmp_adr),
		.jmp_condition (jmp_condition)
	);

	csr_array u_csr_array (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd         (cmd),
		.rs1         (alu_a),
		.cpu_stat    (cpu_stat),
		.pc_excep    (pc_excep),
		.csr_rd_data (csr_rd_data),
		.trap_take   (trap_take),
		.mret_take   (mret_take),
		.mtvec       (mtvec),
		.mepc        (mepc),
		.csr_mie     (csr_mie)
	);

	assign exception = trap_take;

	// write-back data
	always_comb begin
		case (cmd.kind)
			k_lui:         rd_data = {cmd.imm20, 12'd0};
			k_jal, k_jalr: rd_data = pcp4;
			k_auipc:       rd_data = jump_adr;
			k_csr:         rd_data = csr_rd_data;
			default:       rd_data = alu_result;
		endcase
	end

	// a stall turns the slot into a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_q  <= 1'b0;
			st_q  <= 1'b0;
			wbk_q <= 1'b0;
		end else begin
			ld_q  <= (cmd.kind == k_ld) & cpu_stat;
			st_q  <= (cmd.kind == k_st) & cpu_stat;
			wbk_q <= cmd.wbk & ~trap_take & cpu_stat;
		end
	end

	always_ff @(posedge clk) begin
		rd_adr_q    <= cmd.rd_adr;
		rd_data_q   <= rd_data;
		st_data_q   <= cmd.rs2_data;
		ldst_code_q <= cmd.funct3;
	end

	assign ma.ld        = ld_q;
	assign ma.st        = st_q;
	assign ma.wbk       = wbk_q;
	assign ma.rd_adr    = rd_adr_q;
	assign ma.rd_data   = rd_data_q;
	assign ma.st_data   = st_data_q;
	assign ma.ldst_code = ldst_code_q;

endmodule

// ==== execution_properties.sv ====
/*
 * concurrent assertions on the execute stage outputs, bound to execution
 */
`timescale 1ns/1ps

module execution_properties (
	input logic                clk,
	input logic                rst_n,
	input logic                cpu_stat,
	input rv_exec_pkg::ex_ma_t ma,
	input logic                exception,
	input logic                jmp_condition
);

	// controls come out of reset cleared
	ctrl_reset_a: assert property (@(posedge clk) !rst_n |=> !ma.ld && !ma.st && !ma.wbk)
		else $error("ma controls set after a reset cycle");

	ld_st_excl_a: assert property (@(posedge clk) disable iff (!rst_n) !(ma.ld && ma.st))
		else $error("ma.ld and ma.st both high");

	exc_redirect_a: assert property (@(posedge clk) disable iff (!rst_n)
		exception |-> jmp_condition)
		else $error("exception without jmp_condition");

	// a stall cycle leaves a bubble
	stall_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
		!cpu_stat |=> !ma.ld && !ma.st && !ma.wbk)
		else $error("ma controls set after a stall cycle");

endmodule

bind execution execution_properties u_execution_properties (
	.clk           (clk),
	.rst_n         (rst_n),
	.cpu_stat      (cpu_stat),
	.ma            (ma),
	.exception     (exception),
	.jmp_condition (jmp_condition)
);

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_exec.f --top-module tb_execution -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build error, status $status"
	exit $status
fi

./obj_dir/Vtb_execution
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

exit 0

// ==== rv_exec.f ====
rv_exec_pkg.sv
exec_operand_sel.sv
exec_alu.sv
exec_branch.sv
csr_array.sv
execution.sv
execution_properties.sv
tb_execution.sv

// ==== rv_exec_pkg.sv ====
/*
 * shared types for the rv32i execute stage:
 * command kinds, command and result bundles, csr addresses and trap causes
 */
package rv_exec_pkg;

	// command class from decode
	typedef enum logic [3:0] {
		k_nop,
		k_lui,
		k_auipc,
		k_ld,
		k_alui,
		k_alui_shamt,
		k_alu,
		k_st,
		k_jal,
		k_jalr,
		k_br,
		k_csr,
		k_ecall,
		k_mret,
		k_illegal
	} ex_kind_e;

	// one decoded command per cycle
	typedef struct packed {
		ex_kind_e    kind;
		logic [29:0] pc;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [2:0]  funct3;
		logic        alt;
		logic [11:0] imm12;
		logic [19:0] imm20;
		logic [4:0]  uimm;
		logic [4:0]  rd_adr;
		logic        wbk;
	} ex_cmd_t;

	// bundle to memory access
	typedef struct packed {
		logic        ld;
		logic        st;
		logic        wbk;
		logic [4:0]  rd_adr;
		logic [31:0] rd_data;
		logic [31:0] st_data;
		logic [2:0]  ldst_code;
	} ex_ma_t;

	typedef struct packed {
		logic seq;
		logic slt;
		logic sltu;
	} alu_flags_t;

	typedef struct packed {
		logic meie;
		logic mtie;
		logic msie;
	} csr_mie_t;

	// machine mode csr addresses
	localparam logic [11:0] csr_mie_adr      = 12'h304;
	localparam logic [11:0] csr_mtvec_adr    = 12'h305;
	localparam logic [11:0] csr_mscratch_adr = 12'h340;
	localparam logic [11:0] csr_mepc_adr     = 12'h341;
	localparam logic [11:0] csr_mcause_adr   = 12'h342;

	localparam logic [31:0] cause_illegal = 32'd2;
	localparam logic [31:0] cause_ecall_m = 32'd11;

	// trap vector word address after reset
	localparam logic [29:0] mtvec_reset = 30'h0000_0040;

endpackage

// ==== tb_execution.sv ====
/*
 * testbench for the execute stage: clock, reset, reference model,
 * compare tasks and directed tests
 */
`timescale 1ns/1ps

module tb_execution;

	import rv_exec_pkg::*;

	localparam int wait_limit = 20;

	logic        clk;
	logic        rst_n;
	ex_cmd_t     cmd;
	logic        cpu_stat;
	logic [29:0] pc_excep;
	ex_ma_t      ma;
	logic [29:0] jmp_adr;
	logic        jmp_condition;
	logic        exception;
	csr_mie_t    csr_mie;

	integer      seed = 32'h93bc;
	int          cycle_cnt = 0;

	// reference csr state
	csr_mie_t    m_mie;
	logic [29:0] m_mtvec;
	logic [31:0] m_mscratch;
	logic [29:0] m_mepc;
	logic [31:0] m_mcause;

	execution u_execution (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd           (cmd),
		.cpu_stat      (cpu_stat),
		.pc_excep      (pc_excep),
		.ma            (ma),
		.jmp_adr       (jmp_adr),
		.jmp_condition (jmp_condition),
		.exception     (exception),
		.csr_mie       (csr_mie)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_ma(input ex_ma_t got, input ex_ma_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED ma got %h expected %h", got, exp));
	endtask

	task automatic check_redirect(input logic [29:0] adr_got, input logic [29:0] adr_exp,
			input logic jc_got, input logic jc_exp, input logic exc_got, input logic exc_exp);
		if (jc_got !== jc_exp)
			stop_run($sformatf("FAILED jmp_condition got %h expected %h", jc_got, jc_exp));
		else if (adr_got !== adr_exp)
			stop_run($sformatf("FAILED jmp_adr got %h expected %h", adr_got, adr_exp));
		else if (exc_got !== exc_exp)
			stop_run($sformatf("FAILED exception got %h expected %h", exc_got, exc_exp));
	endtask

	task automatic check_mie(input csr_mie_t got, input csr_mie_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED csr_mie got %h expected %h", got, exp));
	endtask

	// bounded wait for n more rising edges, returns on a falling edge
	task automatic wait_cycles(input int n);
		int target;
		int tries;
		target = cycle_cnt + n;
		tries = 0;
		while (cycle_cnt < target) begin
			if (tries == wait_limit)
				stop_run("timeout while waiting for the clock to advance");
			@(negedge clk);
			tries++;
		end
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// alu result as the isa defines it
	function automatic logic [31:0] model_alu(input ex_cmd_t c);
		logic [31:0] a;
		logic [31:0] b;
		a = c.rs1_data;
		b = c.rs2_data;
		if (c.kind inside {k_ld, k_alui, k_st})
			b = sext12(c.imm12);
		if (c.kind == k_alui_shamt)
			b = {27'd0, c.uimm};
		if (c.kind inside {k_ld, k_st})
			return a + b;
		case (c.funct3)
			3'd0: return (c.kind == k_alu && c.alt) ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (c.alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// byte target of auipc, jal, jalr and branches
	function automatic logic [31:0] model_target(input ex_cmd_t c);
		logic [31:0] base;
		base = {c.pc, 2'b00};
		case (c.kind)
			k_auipc: return base + {c.imm20, 12'd0};
			k_jal:   return base + {{11{c.imm20[19]}}, c.imm20, 1'b0};
			k_jalr:  return c.rs1_data + sext12(c.imm12);
			default: return base + {{19{c.imm12[11]}}, c.imm12, 1'b0};
		endcase
	endfunction

	function automatic logic model_taken(input ex_cmd_t c);
		case (c.funct3)
			3'd0: return c.rs1_data == c.rs2_data;
			3'd1: return c.rs1_data != c.rs2_data;
			3'd4: return $signed(c.rs1_data) < $signed(c.rs2_data);
			3'd5: return $signed(c.rs1_data) >= $signed(c.rs2_data);
			3'd6: return c.rs1_data < c.rs2_data;
			3'd7: return c.rs1_data >= c.rs2_data;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] model_csr(input logic [11:0] adr);
		case (adr)
			csr_mie_adr:      return {20'd0, m_mie.meie, 3'd0, m_mie.mtie, 3'd0, m_mie.msie, 3'd0};
			csr_mtvec_adr:    return {m_mtvec, 2'b00};
			csr_mscratch_adr: return m_mscratch;
			csr_mepc_adr:     return {m_mepc, 2'b00};
			csr_mcause_adr:   return m_mcause;
			default:          return 32'd0;
		endcase
	endfunction

	task automatic model_csr_write(input ex_cmd_t c);
		logic [31:0] src;
		logic [31:0] nv;
		src = c.funct3[2] ? {27'd0, c.uimm} : c.rs1_data;
		nv = model_csr(c.imm12);
		case (c.funct3[1:0])
			2'd1: nv = src;
			2'd2: nv = nv | src;
			2'd3: nv = nv & ~src;
			default: return;
		endcase
		case (c.imm12)
			csr_mie_adr:      m_mie = {nv[11], nv[7], nv[3]};
			csr_mtvec_adr:    m_mtvec = nv[31:2];
			csr_mscratch_adr: m_mscratch = nv;
			csr_mepc_adr:     m_mepc = nv[31:2];
			csr_mcause_adr:   m_mcause = nv;
			default: ;
		endcase
	endtask

	// one command: predict, drive, check redirect mid-cycle, then ma
	task automatic step(input ex_cmd_t c);
		ex_ma_t      exp_ma;
		logic        trap;
		logic        mret;
		logic        exp_jc;
		logic [31:0] tgt;
		logic [31:0] r;
		r = rand32();
		pc_excep = r[29:0];
		trap = (c.kind inside {k_ecall, k_illegal}) && cpu_stat;
		mret = (c.kind == k_mret) && cpu_stat;
		exp_ma.ld = (c.kind == k_ld) && cpu_stat;
		exp_ma.st = (c.kind == k_st) && cpu_stat;
		exp_ma.wbk = c.wbk && cpu_stat && !trap;
		exp_ma.rd_adr = c.rd_adr;
		exp_ma.st_data = c.rs2_data;
		exp_ma.ldst_code = c.funct3;
		tgt = model_target(c);
		case (c.kind)
			k_lui:         exp_ma.rd_data = {c.imm20, 12'd0};
			k_auipc:       exp_ma.rd_data = tgt;
			k_jal, k_jalr: exp_ma.rd_data = {c.pc, 2'b00} + 32'd4;
			k_csr:         exp_ma.rd_data = model_csr(c.imm12);
			default:       exp_ma.rd_data = model_alu(c);
		endcase
		exp_jc = trap || mret || (c.kind inside {k_jal, k_jalr}) ||
			(c.kind == k_br && model_taken(c));
		cmd = c;
		#1;
		if (trap || mret || (c.kind inside {k_br, k_jal, k_jalr}))
			check_redirect(jmp_adr, trap ? m_mtvec : mret ? m_mepc : tgt[31:2],
				jmp_condition, exp_jc, exception, trap);
		if (trap) begin
			m_mepc = pc_excep;
			m_mcause = (c.kind == k_ecall) ? cause_ecall_m : cause_illegal;
		end else if (c.kind == k_csr && cpu_stat) begin
			model_csr_write(c);
		end
		wait_cycles(1);
		check_ma(ma, exp_ma);
		check_mie(csr_mie, m_mie);
	endtask

	function automatic ex_cmd_t make_cmd(input ex_kind_e kind, input logic [2:0] f3,
			input logic alt);
		ex_cmd_t     c;
		logic [31:0] r;
		r = rand32();
		c.kind = kind;
		c.pc = r[29:0];
		c.rs1_data = rand32();
		c.rs2_data = rand32();
		c.funct3 = f3;
		c.alt = alt;
		r = rand32();
		c.imm12 = r[11:0];
		c.imm20 = r[31:12];
		r = rand32();
		c.uimm = r[4:0];
		c.rd_adr = r[9:5];
		c.wbk = 1'b1;
		return c;
	endfunction

	// csrrs with a zero source
	task automatic read_csr(input logic [11:0] adr);
		ex_cmd_t c;
		c = make_cmd(k_csr, 3'd2, 1'b0);
		c.imm12 = adr;
		c.rs1_data = 32'd0;
		step(c);
	endtask

	task automatic test_alu();
		for (int f = 0; f < 8; f++) begin
			step(make_cmd(k_alu, 3'(f), 1'b0));
			if (f == 1 || f == 5)
				step(make_cmd(k_alui_shamt, 3'(f), f == 5));
			else
				step(make_cmd(k_alui, 3'(f), 1'b0));
		end
		// sub and sra
		step(make_cmd(k_alu, 3'd0, 1'b1));
		step(make_cmd(k_alu, 3'd5, 1'b1));
	endtask

	task automatic test_mem_upper();
		ex_cmd_t c;
		step(make_cmd(k_lui, 3'd0, 1'b0));
		step(make_cmd(k_auipc, 3'd0, 1'b0));
		for (int f = 0; f < 6; f++) begin
			step(make_cmd(k_ld, 3'(f), 1'b0));
			c = make_cmd(k_st, 3'(f % 3), 1'b0);
			c.wbk = 1'b0;
			step(c);
		end
	endtask

	task automatic test_branches();
		ex_cmd_t     c;
		logic [31:0] pos;
		logic [31:0] neg;
		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3)
				continue;
			// equal, negative vs positive, positive vs negative
			for (int p = 0; p < 3; p++) begin
				c = make_cmd(k_br, 3'(f), 1'b0);
				c.wbk = 1'b0;
				pos = rand32() & 32'h7fff_ffff;
				neg = rand32() | 32'h8000_0000;
				if (p == 0) begin
					c.rs2_data = c.rs1_data;
				end else if (p == 1) begin
					c.rs1_data = neg;
					c.rs2_data = pos;
				end else begin
					c.rs1_data = pos;
					c.rs2_data = neg;
				end
				step(c);
			end
		end
		step(make_cmd(k_jal, 3'd0, 1'b0));
		step(make_cmd(k_jalr, 3'd0, 1'b0));
	endtask

	task automatic test_csr();
		ex_cmd_t     c;
		logic [11:0] adrs[6];
		adrs = '{csr_mie_adr, csr_mtvec_adr, csr_mscratch_adr, csr_mepc_adr,
			csr_mcause_adr, 12'h7c0};
		foreach (adrs[i]) begin
			for (int f = 1; f < 8; f++) begin
				if (f == 4)
					continue;
				c = make_cmd(k_csr, 3'(f), 1'b0);
				c.imm12 = adrs[i];
				step(c);
				read_csr(adrs[i]);
			end
		end
	endtask

	task automatic test_traps();
		step(make_cmd(k_ecall, 3'd0, 1'b0));
		read_csr(csr_mcause_adr);
		read_csr(csr_mepc_adr);
		step(make_cmd(k_mret, 3'd0, 1'b0));
		step(make_cmd(k_illegal, 3'd0, 1'b0));
		read_csr(csr_mcause_adr);
		read_csr(csr_mepc_adr);
		step(make_cmd(k_mret, 3'd0, 1'b0));
	endtask

	task automatic test_stall();
		ex_cmd_t c;
		cpu_stat = 1'b0;
		c = make_cmd(k_csr, 3'd1, 1'b0);
		c.imm12 = csr_mscratch_adr;
		step(c);
		c.imm12 = csr_mie_adr;
		step(c);
		step(make_cmd(k_ecall, 3'd0, 1'b0));
		step(make_cmd(k_illegal, 3'd0, 1'b0));
		step(make_cmd(k_ld, 3'd2, 1'b0));
		step(make_cmd(k_st, 3'd2, 1'b0));
		step(make_cmd(k_mret, 3'd0, 1'b0));
		cpu_stat = 1'b1;
		read_csr(csr_mie_adr);
		read_csr(csr_mscratch_adr);
		read_csr(csr_mepc_adr);
		read_csr(csr_mcause_adr);
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_stat = 1'b0;
		pc_excep = 30'd0;
		cmd = '0;
		m_mie = '0;
		m_mtvec = mtvec_reset;
		m_mscratch = 32'd0;
		m_mepc = 30'd0;
		m_mcause = 32'd0;
		wait_cycles(2);
		rst_n = 1'b1;
		cpu_stat = 1'b1;
		check_mie(csr_mie, m_mie);
		test_alu();
		test_mem_upper();
		test_branches();
		test_csr();
		test_traps();
		test_stall();
		$display("Verification passed");
		$finish;
	end

endmodule
